/* slave_xlat_top.f */
+incdir+logic
logic/slave_xlat_pkg.sv
logic/wait_state_ctrl.sv
logic/cmd_mapper.sv
logic/transfer_marker.sv
logic/read_latency_tracker.sv
logic/slave_xlat_top.sv
tests/slave_xlat_sva.sv
tests/slave_xlat_tb.sv

/* Bender.yml */
package:
  name: slave_xlat

sources:
  - include_dirs:
      - logic
    files:
      - logic/slave_xlat_pkg.sv
      - logic/wait_state_ctrl.sv
      - logic/cmd_mapper.sv
      - logic/transfer_marker.sv
      - logic/read_latency_tracker.sv
      - logic/slave_xlat_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/slave_xlat_sva.sv
      - tests/slave_xlat_tb.sv

/* tests/slave_xlat_tb.sv */
// testbench for the slave translator with a fixed-timing slave model and directed commands
`timescale 1ns/100ps
`include "slave_xlat_params.svh"

module slave_xlat_tb
   import slave_xlat_pkg::*;
();

   logic                     clk;
   logic                     reset;
   uav_cmd_t                 uav_cmd;
   logic [`SX_DATA_W-1:0]    uav_readdata;
   logic                     uav_waitrequest;
   logic                     uav_readdatavalid;
   av_cmd_t                  av_cmd;
   logic                     av_read;
   logic                     av_write;
   logic                     av_chipselect;
   logic                     av_outputenable;
   logic                     av_begintransfer;
   logic                     av_beginbursttransfer;
   logic [`SX_DATA_W-1:0]    av_readdata;

   logic [`SX_AV_ADDR_W-1:0] last_rd_addr = '0;   // slave model
   logic [`SX_AV_ADDR_W-1:0] pend_addr[$];        // accepted reads awaiting data
   int unsigned              pend_cycle[$];
   int unsigned              cycle = 0;
   int unsigned              mismatch_count = 0;
   int unsigned              fault_count = 0;
   int unsigned              reads_accepted = 0;
   int unsigned              rdv_seen = 0;

   slave_xlat_top dut (.*);
   bind slave_xlat_top slave_xlat_sva u_sva (.*);

   // slave memory contents per word address
   function automatic logic [`SX_DATA_W-1:0] expected_rdata(
      input logic [`SX_AV_ADDR_W-1:0] addr);
      return {addr[13:0], addr[29:12]} ^ 32'h3c5a_96e1;
   endfunction

   // slave-side view of a beat with the burst's first address and count
   function automatic av_cmd_t expected_av(input uav_cmd_t c, input uav_cmd_t first);
      av_cmd_t e;
      e.address         = first.address[`SX_AV_ADDR_W+`SX_WORD_SHIFT-1:`SX_WORD_SHIFT];
      e.writedata       = c.writedata;
      e.byteenable      = c.byteenable;
      e.writebyteenable = c.write ? c.byteenable : '0;
      e.burstcount      = first.burstcount[`SX_AV_BURST_W+`SX_WORD_SHIFT-1:`SX_WORD_SHIFT];
      return e;
   endfunction

   function automatic uav_cmd_t make_cmd(input logic rd, input logic [31:0] addr,
                                         input logic [`SX_UAV_BURST_W-1:0] bytes);
      uav_cmd_t c;
      c.address    = addr;
      c.writedata  = rd ? '0 : $urandom();
      c.byteenable = `SX_BE_W'($urandom());
      c.burstcount = bytes;
      c.read       = rd;
      c.write      = ~rd;
      return c;
   endfunction

   // ----------------------------------------
   // compare tasks
   // ----------------------------------------
   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         mismatch_count++;
         $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_data(input string name, input logic [`SX_DATA_W-1:0] got,
                             input logic [`SX_DATA_W-1:0] exp);
      if (got !== exp) begin
         mismatch_count++;
         $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_av_cmd(input string name, input av_cmd_t got, input av_cmd_t exp);
      if (got !== exp) begin
         mismatch_count++;
         $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
      end
   endtask

   // ----------------------------------------
   // clock, slave model and read compare
   // ----------------------------------------
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) cycle <= cycle + 1;

   always @(posedge clk or posedge reset) begin
      if (reset)
         last_rd_addr <= '0;
      else if (av_read)
         last_rd_addr <= av_cmd.address;   // last word address read
   end
   assign av_readdata = expected_rdata(last_rd_addr);

   always @(negedge clk) begin
      if (!reset && uav_cmd.read && !uav_waitrequest) begin
         pend_addr.push_back(uav_cmd.address[`SX_AV_ADDR_W+`SX_WORD_SHIFT-1:`SX_WORD_SHIFT]);
         pend_cycle.push_back(cycle + `SX_READ_LATENCY);
         reads_accepted++;
      end
      if (!reset && uav_readdatavalid) begin
         rdv_seen++;
         if (pend_addr.size() == 0) begin
            fault_count++;
            $display("readdatavalid came with no read outstanding at %0t", $time);
         end else begin
            check_data("uav_readdatavalid cycle", cycle, pend_cycle.pop_front());
            check_data("uav_readdata", uav_readdata, expected_rdata(pend_addr.pop_front()));
         end
      end
   end

   // hold one command until accepted and check each held cycle
   task automatic issue_cmd(input uav_cmd_t c, input av_cmd_t exp_av, input logic exp_bbt);
      int n;
      int accept_n;
      n = 0;
      accept_n = c.write ? `SX_SETUP_CYCLES + `SX_WRITE_WAIT_CYCLES + `SX_HOLD_CYCLES + 1
                         : `SX_SETUP_CYCLES + `SX_READ_WAIT_CYCLES + 1;
      uav_cmd = c;
      do begin
         @(negedge clk);
         n++;
         check_bit("uav_waitrequest", uav_waitrequest, n != accept_n);
         check_bit("av_begintransfer", av_begintransfer, n == 1);
         check_bit("av_beginbursttransfer", av_beginbursttransfer, exp_bbt && n == 1);
         check_bit("av_read", av_read, c.read && n >= 2);
         check_bit("av_write", av_write, c.write && n >= 2 && n <= 4);
         check_bit("av_chipselect", av_chipselect, 1'b1);
         check_bit("av_outputenable", av_outputenable, c.read);
         check_av_cmd("av_cmd", av_cmd, exp_av);
      end while (uav_waitrequest && n < 12);
      if (uav_waitrequest) begin
         fault_count++;
         $display("command at byte address %h was never accepted", c.address);
      end
      @(posedge clk);
      #1;
   endtask

   // go idle until all read data is back and optionally check the held selects
   task automatic wait_read_data(input logic check_extension);
      int n;
      n = 0;
      uav_cmd = '0;
      while (pend_addr.size() != 0 && n < 16) begin
         @(negedge clk);
         n++;
         if (check_extension) begin
            check_bit("av_chipselect", av_chipselect, 1'b1);
            check_bit("av_outputenable", av_outputenable, 1'b1);
         end
         @(posedge clk);
      end
      if (pend_addr.size() != 0) begin
         fault_count++;
         $display("read data did not come back for %0d reads", pend_addr.size());
      end
      #1;
   endtask

   // ----------------------------------------
   // stimulus
   // ----------------------------------------
   initial begin
      logic [31:0] base;
      uav_cmd_t    c;
      uav_cmd_t    first;
      void'($urandom(32'h6e13f604));
      reset   = 1'b1;
      uav_cmd = '0;
      repeat (4) @(posedge clk);
      #1 reset = 1'b0;
      @(negedge clk);   // reset window
      check_bit("uav_waitrequest", uav_waitrequest, 1'b1);
      check_bit("av_begintransfer", av_begintransfer, 1'b0);
      check_bit("av_chipselect", av_chipselect, 1'b0);
      check_bit("av_outputenable", av_outputenable, 1'b0);
      check_bit("uav_readdatavalid", uav_readdatavalid, 1'b0);
      @(posedge clk);
      #1;

      c = make_cmd(1'b0, $urandom() & 32'hffff_fffc, 6'd4);
      issue_cmd(c, expected_av(c, c), 1'b1);
      c = make_cmd(1'b1, $urandom() & 32'hffff_fffc, 6'd4);
      issue_cmd(c, expected_av(c, c), 1'b1);
      wait_read_data(1'b1);

      repeat (3) begin   // no gap between reads
         c = make_cmd(1'b1, $urandom() & 32'hffff_fffc, 6'd4);
         issue_cmd(c, expected_av(c, c), 1'b1);
      end
      wait_read_data(1'b0);

      // 16-byte burst whose remaining byte count drops by one word per beat
      base  = $urandom() & 32'hffff_ffc0;
      first = make_cmd(1'b0, base, 6'd16);
      for (int i = 0; i < 4; i++) begin
         c = (i == 0) ? first : make_cmd(1'b0, base + 4 * i, 6'(16 - 4 * i));
         issue_cmd(c, expected_av(c, first), i == 0);
      end
      uav_cmd = '0;
      repeat (4) @(posedge clk);

      check_data("reads accepted", reads_accepted, 4);
      check_data("uav_readdatavalid pulses", rdv_seen, 4);
      $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
               mismatch_count, fault_count, dut.u_sva.assert_failures);
      if (mismatch_count == 0 && fault_count == 0 && dut.u_sva.assert_failures == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

/* tests/slave_xlat_sva.sv */
// slave translator assertions on write gating, read latency and begintransfer width
`timescale 1ns/100ps
`include "slave_xlat_params.svh"

module slave_xlat_sva
   import slave_xlat_pkg::*;
(
   input logic     clk,
   input logic     reset,
   input uav_cmd_t uav_cmd,
   input logic     uav_waitrequest,
   input logic     uav_readdatavalid,
   input logic     av_write,
   input logic     av_begintransfer
);

   int unsigned assert_failures = 0;   // count of failed assertions

   // ----------------------------------------
   // protocol properties
   // ----------------------------------------
   a_write_gated: assert property (@(posedge clk) disable iff (reset)
      uav_cmd.read |-> !$rose(av_write))
      else begin
         assert_failures++;
         $error("av_write rose while read was high");
      end

   // data returns a fixed latency after acceptance
   a_read_latency: assert property (@(posedge clk) disable iff (reset)
      (uav_cmd.read && !uav_waitrequest) |-> ##`SX_READ_LATENCY uav_readdatavalid)
      else begin
         assert_failures++;
         $error("readdatavalid missing after an accepted read");
      end

   a_begin_one_cycle: assert property (@(posedge clk) disable iff (reset)
      av_begintransfer |=> !av_begintransfer)
      else begin
         assert_failures++;
         $error("av_begintransfer held longer than one cycle");
      end

endmodule

/* logic/slave_xlat_top.sv */
// slave translator top: universal byte-addressed port to fixed-timing word slave
`timescale 1ns/100ps
`include "slave_xlat_params.svh"

module slave_xlat_top
   import slave_xlat_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,

   // fabric side
   input  uav_cmd_t              uav_cmd,
   output logic [`SX_DATA_W-1:0] uav_readdata,
   output logic                  uav_waitrequest,
   output logic                  uav_readdatavalid,

   // slave side
   output av_cmd_t               av_cmd,
   output logic                  av_read,
   output logic                  av_write,
   output logic                  av_chipselect,
   output logic                  av_outputenable,
   output logic                  av_begintransfer,
   output logic                  av_beginbursttransfer,
   input  logic [`SX_DATA_W-1:0] av_readdata
);

   logic stall;
   logic read_accept;

   // same width both sides
   assign uav_readdata = av_readdata;

   // ----------------------------------------
   // blocks
   // ----------------------------------------
   wait_state_ctrl u_wait_state_ctrl (
      .clk             (clk),
      .reset           (reset),
      .uav_cmd         (uav_cmd),
      .uav_waitrequest (uav_waitrequest),
      .stall           (stall),
      .read_accept     (read_accept),
      .av_read         (av_read),
      .av_write        (av_write)
   );

   cmd_mapper u_cmd_mapper (
      .clk                   (clk),
      .reset                 (reset),
      .uav_cmd               (uav_cmd),
      .av_beginbursttransfer (av_beginbursttransfer),
      .av_cmd                (av_cmd)
   );

   transfer_marker u_transfer_marker (
      .clk                   (clk),
      .reset                 (reset),
      .uav_cmd               (uav_cmd),
      .stall                 (stall),
      .av_begintransfer      (av_begintransfer),
      .av_beginbursttransfer (av_beginbursttransfer)
   );

   read_latency_tracker u_read_latency_tracker (
      .clk               (clk),
      .reset             (reset),
      .uav_cmd           (uav_cmd),
      .read_accept       (read_accept),
      .uav_readdatavalid (uav_readdatavalid),
      .av_chipselect     (av_chipselect),
      .av_outputenable   (av_outputenable)
   );

endmodule

/* logic/read_latency_tracker.sv */
// read latency tracker: readdatavalid pipe and chipselect/outputenable extension
`timescale 1ns/100ps
`include "slave_xlat_params.svh"

module read_latency_tracker
   import slave_xlat_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  uav_cmd_t uav_cmd,
   input  logic     read_accept,
   output logic     uav_readdatavalid,
   output logic     av_chipselect,
   output logic     av_outputenable
);

   logic [`SX_READ_LATENCY-1:0] rd_pipe;   // one bit per cycle of latency
   logic                        extension; // read still short of its data
   logic                        hold_q;

   // ----------------------------------------
   // latency pipe
   // ----------------------------------------
   // several reads may be in flight, one bit each
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         rd_pipe <= '0;
      else
         rd_pipe <= {rd_pipe[`SX_READ_LATENCY-2:0], read_accept};
   end

   assign uav_readdatavalid = rd_pipe[`SX_READ_LATENCY-1];

   // any stage but the last
   always_comb begin
      extension = 1'b0;
      for (int i = 0; i < `SX_READ_LATENCY - 1; i++) begin
         extension = extension | rd_pipe[i];
      end
   end

   // ----------------------------------------
   // chipselect and outputenable
   // ----------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         hold_q <= 1'b0;
      else
         hold_q <= uav_cmd.read | extension;
   end

   // both stay up until the data comes back
   assign av_chipselect   = uav_cmd.read | uav_cmd.write | hold_q;
   assign av_outputenable = uav_cmd.read | hold_q;

endmodule

/* logic/transfer_marker.sv */
// transfer marker: begintransfer per command and beginbursttransfer per burst
`timescale 1ns/100ps
`include "slave_xlat_params.svh"

module transfer_marker
   import slave_xlat_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  uav_cmd_t uav_cmd,
   input  logic     stall,
   output logic     av_begintransfer,
   output logic     av_beginbursttransfer
);

   logic end_begin;     // masks the rest of a stalled command
   logic end_burst;     // last write beat was not the final one
   logic in_burst;      // write burst still open

   // ----------------------------------------
   // begintransfer
   // ----------------------------------------
   assign av_begintransfer = (uav_cmd.read | uav_cmd.write) & ~end_begin;

   // set at reset so the reset window shows no strobe,
   // stall is low in that window and clears it
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         end_begin <= 1'b1;
      else if (av_begintransfer && stall)
         end_begin <= 1'b1;
      else if (!stall)
         end_begin <= 1'b0;                    // accepted
   end

   // ----------------------------------------
   // beginbursttransfer
   // ----------------------------------------
   always_comb begin
      if (uav_cmd.read)
         av_beginbursttransfer = av_begintransfer;
      else
         av_beginbursttransfer = av_begintransfer & ~end_burst & ~in_burst;
   end

   // final beat carries one word of byte count
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_burst <= 1'b0;
         in_burst  <= 1'b0;
      end else begin
         end_burst <= uav_cmd.write && (uav_cmd.burstcount != `SX_BYTES_PER_WORD);
         if (uav_cmd.write)
            in_burst <= (uav_cmd.burstcount != `SX_BYTES_PER_WORD);
      end
   end

endmodule

/* logic/cmd_mapper.sv */
// command mapper: byte address and burst count to word units, held across a burst
`timescale 1ns/100ps
`include "slave_xlat_params.svh"

module cmd_mapper
   import slave_xlat_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  uav_cmd_t uav_cmd,
   input  logic     av_beginbursttransfer,
   output av_cmd_t  av_cmd
);

   logic [`SX_AV_ADDR_W-1:0]  word_addr;
   logic [`SX_AV_BURST_W-1:0] word_burst;
   logic [`SX_AV_ADDR_W-1:0]  addr_q;    // first beat's address
   logic [`SX_AV_BURST_W-1:0] burst_q;   // first beat's burst count

   // ----------------------------------------
   // byte to word conversion
   // ----------------------------------------
   assign word_addr =
      uav_cmd.address[`SX_AV_ADDR_W + `SX_WORD_SHIFT - 1 : `SX_WORD_SHIFT];
   assign word_burst =
      uav_cmd.burstcount[`SX_AV_BURST_W + `SX_WORD_SHIFT - 1 : `SX_WORD_SHIFT];

   // capture on the burst's first cycle
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         addr_q  <= '0;
         burst_q <= '0;
      end else if (av_beginbursttransfer) begin
         addr_q  <= word_addr;
         burst_q <= word_burst;
      end
   end

   // ----------------------------------------
   // slave side command
   // ----------------------------------------
   always_comb begin
      av_cmd.writedata       = uav_cmd.writedata;
      av_cmd.byteenable      = uav_cmd.byteenable;
      av_cmd.writebyteenable = uav_cmd.byteenable & {`SX_BE_W{uav_cmd.write}};

      // constant-burst slave sees the first beat's values on every beat
      if (av_beginbursttransfer) begin
         av_cmd.address    = word_addr;
         av_cmd.burstcount = word_burst;
      end else begin
         av_cmd.address    = addr_q;
         av_cmd.burstcount = burst_q;
      end
   end

endmodule

/* logic/wait_state_ctrl.sv */
// wait-state controller: counts the slave's fixed wait cycles and generates waitrequest
`timescale 1ns/100ps
`include "slave_xlat_params.svh"

module wait_state_ctrl
   import slave_xlat_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  uav_cmd_t uav_cmd,
   output logic     uav_waitrequest,
   output logic     stall,
   output logic     read_accept,
   output logic     av_read,
   output logic     av_write
);

   // counts at which a held command is accepted
   localparam int unsigned SETUP_CNT     = `SX_SETUP_CYCLES;
   localparam int unsigned READ_DONE_CNT = `SX_SETUP_CYCLES + `SX_READ_WAIT_CYCLES;
   localparam int unsigned WR_END_CNT    = `SX_SETUP_CYCLES + `SX_WRITE_WAIT_CYCLES;
   localparam int unsigned WR_DONE_CNT   = WR_END_CNT + `SX_HOLD_CYCLES;

   ctrl_state_e           state;
   xfer_op_e              op;
   logic [`SX_CNT_W-1:0]  wait_cnt;
   logic                  override;    // reset window
   logic                  wait_gen;

   // ----------------------------------------
   // operation decode
   // ----------------------------------------
   always_comb begin
      if (uav_cmd.write)
         op = OP_WRITE;
      else if (uav_cmd.read)
         op = OP_READ;
      else
         op = OP_NONE;
   end

   assign override = (state == WS_RESET);

   // ----------------------------------------
   // state and wait counter
   // ----------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state    <= WS_RESET;
         wait_cnt <= '0;
      end else begin
         state <= WS_ACTIVE;
         if (!uav_waitrequest || override)
            wait_cnt <= '0;                    // accepted, next command starts at 0
         else if (op != OP_NONE)
            wait_cnt <= wait_cnt + 1'b1;
         else
            wait_cnt <= '0;
      end
   end

   // waitrequest drops only on the last wait cycle of the operation
   always_comb begin
      case (op)
         OP_READ:  wait_gen = (wait_cnt != READ_DONE_CNT);
         OP_WRITE: wait_gen = (wait_cnt != WR_DONE_CNT);
         default:  wait_gen = 1'b1;
      endcase
   end

   assign uav_waitrequest = wait_gen | override;
   assign stall           = uav_waitrequest & ~override;

   // waitrequest already covers the reset window
   assign read_accept = uav_cmd.read & ~uav_waitrequest;

   // ----------------------------------------
   // slave strobes
   // ----------------------------------------
   assign av_read  = (op == OP_READ) && (wait_cnt >= SETUP_CNT);
   assign av_write = (op == OP_WRITE) && (wait_cnt >= SETUP_CNT) &&
                     (wait_cnt <= WR_END_CNT);   // off during hold phase

endmodule

/* logic/slave_xlat_pkg.sv */
// slave translator types: command structs on both sides, control state and operation
`include "slave_xlat_params.svh"

package slave_xlat_pkg;

   // ----------------------------------------
   // command structs
   // ----------------------------------------

   // fabric side, byte addressed
   typedef struct packed {
      logic [`SX_UAV_ADDR_W-1:0]  address;
      logic [`SX_DATA_W-1:0]      writedata;
      logic [`SX_BE_W-1:0]        byteenable;
      logic [`SX_UAV_BURST_W-1:0] burstcount;  // in bytes
      logic                       read;
      logic                       write;
   } uav_cmd_t;

   // slave side, word addressed
   typedef struct packed {
      logic [`SX_AV_ADDR_W-1:0]  address;
      logic [`SX_DATA_W-1:0]     writedata;
      logic [`SX_BE_W-1:0]       byteenable;
      logic [`SX_BE_W-1:0]       writebyteenable;  // zero unless writing
      logic [`SX_AV_BURST_W-1:0] burstcount;       // in words
   } av_cmd_t;

   // ----------------------------------------
   // control encodings
   // ----------------------------------------

   // WS_RESET lasts one cycle after reset, waitrequest forced high
   typedef enum logic {
      WS_RESET,
      WS_ACTIVE
   } ctrl_state_e;

   typedef enum logic [1:0] {
      OP_NONE,
      OP_READ,
      OP_WRITE
   } xfer_op_e;

endpackage

/* logic/slave_xlat_params.svh */
// slave translator parameters: port widths, fixed wait-state timing and read latency
`ifndef SLAVE_XLAT_PARAMS_SVH
`define SLAVE_XLAT_PARAMS_SVH

// ----------------------------------------
// widths
// ----------------------------------------
`define SX_UAV_ADDR_W        32   // fabric side, byte address
`define SX_AV_ADDR_W         30   // slave side, word address
`define SX_DATA_W            32
`define SX_BE_W              4
`define SX_WORD_SHIFT        2    // log2 of bytes per word
`define SX_UAV_BURST_W       6    // burst count in bytes
`define SX_AV_BURST_W        4    // burst count in words
`define SX_BYTES_PER_WORD    4

// ----------------------------------------
// slave timing
// ----------------------------------------
`define SX_SETUP_CYCLES      1
`define SX_READ_WAIT_CYCLES  2
`define SX_WRITE_WAIT_CYCLES 2
`define SX_HOLD_CYCLES       1
`define SX_READ_LATENCY      2

// wait counter must reach setup + write wait + hold
`define SX_CNT_W             3

`endif
